//--- hdl/id_pkg.sv
// Decode-stage package: opcodes, ALU codes, control-bit layout and instruction views
`default_nettype none

package id_pkg;

    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    // custom-0 space, coprocessor instructions
    localparam logic [6:0] op_npu    = 7'b0001011;

    localparam logic [3:0] alu_and = 4'd0;
    localparam logic [3:0] alu_or  = 4'd1;
    localparam logic [3:0] alu_add = 4'd2;
    localparam logic [3:0] alu_xor = 4'd3;
    localparam logic [3:0] alu_sub = 4'd6;
    localparam logic [3:0] alu_slt = 4'd7;
    localparam logic [3:0] alu_npu = 4'd8;

    // Bit positions in the 6-bit execute control field
    localparam int ex_alu_src    = 5;
    localparam int ex_mem_to_reg = 4;
    localparam int ex_reg_write  = 3;
    localparam int ex_mem_read   = 2;
    localparam int ex_mem_write  = 1;
    localparam int ex_branch     = 0;

    localparam logic [1:0] aluop_mem    = 2'd0;
    localparam logic [1:0] aluop_branch = 2'd1;
    localparam logic [1:0] aluop_funct  = 2'd2;
    localparam logic [1:0] aluop_npu    = 2'd3;

    localparam logic [4:0] npu_doorbell_reg = 5'd13;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_form_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_form_t;

    typedef union packed {
        r_form_t r;
        s_form_t s;
    } rv_inst_t;

endpackage

`default_nettype wire

//--- hdl/id_ctrl_if.sv
// Execute control bundle from decode to the issue gate
`default_nettype none

interface id_ctrl_if;

    logic [5:0] ex_ctrl;
    logic [3:0] alu_code;
    // Branch resolution from later stages, driven by the top level
    logic       flush;
    logic       hit;

    modport decode (
        output ex_ctrl,
        output alu_code
    );

    modport gate (
        input  ex_ctrl,
        input  alu_code
    );

endinterface

`default_nettype wire

//--- hdl/hazard_detect.sv
// Load-use hazard check, stalls decode behind a load in execute
`default_nettype none

module hazard_detect
    import id_pkg::*;
(
    input  logic       mem_read_ex,
    input  logic [4:0] rd_ex,
    input  rv_inst_t   instr,
    output logic       stall
);

    logic rd_live;
    logic src_match;

    // x0 as a destination never creates a dependency
    assign rd_live   = mem_read_ex && (rd_ex != 5'd0);
    assign src_match = (rd_ex == instr.r.rs1) || (rd_ex == instr.r.rs2);

    assign stall = rd_live && src_match;

endmodule

`default_nettype wire

//--- hdl/decode_control.sv
// Main control and ALU control decode, bubbled while stalled
`default_nettype none

module decode_control
    import id_pkg::*;
(
    input  rv_inst_t         instr,
    input  logic             stall,
    id_ctrl_if.decode        ctrl
);

    logic [5:0] ex;
    logic [1:0] alu_op;
    logic [3:0] code;
    logic [1:0] f7_bits;

    // Main control from the opcode
    always_comb begin
        ex     = 6'b0;
        alu_op = aluop_mem;
        case (instr.r.opcode)
            op_load: begin
                ex[ex_alu_src]    = 1'b1;
                ex[ex_mem_to_reg] = 1'b1;
                ex[ex_reg_write]  = 1'b1;
                ex[ex_mem_read]   = 1'b1;
            end
            op_store: begin
                ex[ex_alu_src]   = 1'b1;
                ex[ex_mem_write] = 1'b1;
            end
            op_branch: begin
                ex[ex_branch] = 1'b1;
                alu_op        = aluop_branch;
            end
            op_op: begin
                ex[ex_reg_write] = 1'b1;
                alu_op           = aluop_funct;
            end
            op_op_imm: begin
                ex[ex_alu_src]   = 1'b1;
                ex[ex_reg_write] = 1'b1;
                alu_op           = aluop_funct;
            end
            op_lui: begin
                ex[ex_alu_src]   = 1'b1;
                ex[ex_reg_write] = 1'b1;
            end
            op_jal: begin
                ex[ex_reg_write] = 1'b1;
            end
            op_npu: begin
                ex[ex_reg_write] = 1'b1;
                alu_op           = aluop_npu;
            end
            default: begin
                ex = 6'b0;
            end
        endcase
    end

    // Bit 30 only means sub for register-register ops, immediates reuse it
    assign f7_bits = {instr.r.funct7[5] && (instr.r.opcode == op_op), instr.r.funct7[0]};

    always_comb begin
        code = alu_add;
        case (alu_op)
            aluop_mem:    code = alu_add;
            aluop_branch: code = alu_sub;
            aluop_npu:    code = alu_npu;
            default: begin
                case (instr.r.funct3)
                    3'b000:  code = (f7_bits == 2'b10) ? alu_sub : alu_add;
                    3'b010:  code = alu_slt;
                    3'b100:  code = alu_xor;
                    3'b110:  code = alu_or;
                    3'b111:  code = alu_and;
                    default: code = alu_add;
                endcase
            end
        endcase
    end

    // Bubble into execute while the load-use stall holds
    assign ctrl.ex_ctrl  = stall ? 6'b0 : ex;
    assign ctrl.alu_code = stall ? 4'b0 : code;

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
// General-purpose register file, two reads, writeback and preload write
`default_nettype none

module reg_file #(
    parameter int xlen      = 32,
    parameter int reg_count = 32
) (
    input  logic                         clk_50,
    input  logic                         rst,
    input  logic [$clog2(reg_count)-1:0] rs1,
    input  logic [$clog2(reg_count)-1:0] rs2,
    input  logic [$clog2(reg_count)-1:0] wr,
    input  logic [$clog2(reg_count)-1:0] reg_addr,
    input  logic [xlen-1:0]              wd,
    input  logic [xlen-1:0]              reg_init,
    input  logic                         reg_write,
    input  logic                         reg_load,
    output logic [xlen-1:0]              rd1,
    output logic [xlen-1:0]              rd2
);

    logic [xlen-1:0] regs [reg_count];

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_load) begin
            // Preload blocks writeback for the whole cycle
            if (reg_addr != '0) begin
                regs[reg_addr] <= reg_init;
            end
        end else if (reg_write && (wr != '0)) begin
            regs[wr] <= wd;
        end
    end

    // x0 is never written, so it stays zero from reset
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

`default_nettype wire

//--- hdl/imm_gen.sv
// Immediate extraction and sign extension for I, S, B, U and J formats
`default_nettype none

module imm_gen
    import id_pkg::*;
#(
    parameter int xlen = 32
) (
    input  rv_inst_t        instr,
    output logic [xlen-1:0] imm
);

    always_comb begin
        imm = '0;
        case (instr.r.opcode)
            op_load, op_op_imm: begin
                imm = xlen'(signed'({instr.r.funct7, instr.r.rs2}));
            end
            op_store: begin
                imm = xlen'(signed'({instr.s.imm_hi, instr.s.imm_lo}));
            end
            op_branch: begin
                imm = xlen'(signed'({instr.s.imm_hi[6], instr.s.imm_lo[0],
                                     instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0}));
            end
            // Upper 20 bits, low 12 cleared
            op_lui: begin
                imm = xlen'(signed'({instr.r.funct7, instr.r.rs2, instr.r.rs1,
                                     instr.r.funct3, 12'b0}));
            end
            op_jal: begin
                imm = xlen'(signed'({instr.r.funct7[6], instr.r.rs1, instr.r.funct3,
                                     instr.r.rs2[0], instr.r.funct7[5:0],
                                     instr.r.rs2[4:1], 1'b0}));
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/issue_gate.sv
// Issue gate, squashes execute control on a flush and holds the NPU doorbell
`default_nettype none

module issue_gate
    import id_pkg::*;
(
    input  logic        clk_50,
    input  logic        rst,
    id_ctrl_if.gate     ctrl,
    input  logic        flush,
    input  logic        hit,
    input  logic        reg_write,
    input  logic [4:0]  wr,
    input  logic [31:0] wd,
    input  logic        npu_ack,
    output logic [5:0]  ex_ctrl,
    output logic [3:0]  alu_ctrl,
    output logic        en_npu
);

    logic squash;
    logic ring;

    // Mispredicted path, drop the wrongly fetched instruction
    assign squash   = flush && !hit;
    assign ex_ctrl  = squash ? 6'b0 : ctrl.ex_ctrl;
    assign alu_ctrl = ctrl.alu_code;

    assign ring = reg_write && (wr == npu_doorbell_reg) && (wd != 32'd0);

    // Ack has priority over a new ring in the same cycle
    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            en_npu <= 1'b0;
        end else if (npu_ack) begin
            en_npu <= 1'b0;
        end else if (ring) begin
            en_npu <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
// Instruction decode stage top level for the RV32I pipeline with NPU doorbell
`default_nettype none

module id_stage
    import id_pkg::*;
#(
    parameter int xlen      = 32,
    parameter int reg_count = 32
) (
    input  logic            clk_50,
    input  logic            rst,
    input  logic [31:0]     instr,
    input  logic            mem_read_ex,
    input  logic [4:0]      rd_ex,
    input  logic [4:0]      wr,
    input  logic [xlen-1:0] wd,
    input  logic            reg_write,
    input  logic [4:0]      reg_addr,
    input  logic [xlen-1:0] reg_init,
    input  logic            reg_load,
    input  logic            flush,
    input  logic            hit,
    input  logic            npu_ack,
    output logic            stall,
    output logic [xlen-1:0] rd1,
    output logic [xlen-1:0] rd2,
    output logic [xlen-1:0] imm,
    output logic [5:0]      ex_ctrl,
    output logic [3:0]      alu_ctrl,
    output logic            en_npu
);

    rv_inst_t inst_w;

    id_ctrl_if ctrl_bus ();

    assign inst_w         = instr;
    assign ctrl_bus.flush = flush;
    assign ctrl_bus.hit   = hit;

    hazard_detect u_hazard (
        .mem_read_ex (mem_read_ex),
        .rd_ex       (rd_ex),
        .instr       (inst_w),
        .stall       (stall)
    );

    decode_control u_decode (
        .instr (inst_w),
        .stall (stall),
        .ctrl  (ctrl_bus.decode)
    );

    reg_file #(
        .xlen      (xlen),
        .reg_count (reg_count)
    ) u_regs (
        .clk_50    (clk_50),
        .rst       (rst),
        .rs1       (inst_w.r.rs1),
        .rs2       (inst_w.r.rs2),
        .wr        (wr),
        .reg_addr  (reg_addr),
        .wd        (wd),
        .reg_init  (reg_init),
        .reg_write (reg_write),
        .reg_load  (reg_load),
        .rd1       (rd1),
        .rd2       (rd2)
    );

    imm_gen #(
        .xlen (xlen)
    ) u_imm (
        .instr (inst_w),
        .imm   (imm)
    );

    issue_gate u_gate (
        .clk_50    (clk_50),
        .rst       (rst),
        .ctrl      (ctrl_bus.gate),
        .flush     (ctrl_bus.flush),
        .hit       (ctrl_bus.hit),
        .reg_write (reg_write),
        .wr        (wr),
        .wd        (wd),
        .npu_ack   (npu_ack),
        .ex_ctrl   (ex_ctrl),
        .alu_ctrl  (alu_ctrl),
        .en_npu    (en_npu)
    );

endmodule

`default_nettype wire

//--- dv/id_stage_sva.sv
// Bound checker for the decode stage, shadow register file and doorbell model
`default_nettype none

module id_stage_sva
    import id_pkg::*;
(
    input logic        clk_50, rst, mem_read_ex, reg_write, reg_load,
    input logic        flush, hit, npu_ack, stall, en_npu,
    input logic [4:0]  rd_ex, wr, reg_addr,
    input logic [31:0] instr, wd, reg_init, rd1, rd2, imm,
    input logic [5:0]  ex_ctrl,
    input logic [3:0]  alu_ctrl
);

    timeunit 1ns;
    timeprecision 1ps;

    bit          fail_seen;
    logic [31:0] shadow [32];
    logic [4:0]  tgt_addr;
    logic [31:0] tgt_data;
    logic        tgt_en;
    logic [4:0]  rs1_f;
    logic [4:0]  rs2_f;
    logic [31:0] exp_rd1;
    logic [31:0] exp_rd2;
    logic        exp_stall;
    logic [31:0] exp_imm;
    logic [5:0]  exp_ex;
    logic [3:0]  exp_alu;
    logic        known_op;
    logic        ring;
    logic        bell;

    // Preload takes the write slot, x0 never changes
    assign tgt_addr = reg_load ? reg_addr : wr;
    assign tgt_data = reg_load ? reg_init : wd;
    assign tgt_en   = (reg_load || reg_write) && (tgt_addr != 5'd0);

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= 32'd0;
            end
        end else if (tgt_en) begin
            shadow[tgt_addr] <= tgt_data;
        end
    end

    assign ring = reg_write && (wr == npu_doorbell_reg) && (wd != 32'd0);

    always_ff @(posedge clk_50 or posedge rst) begin
        if (rst) begin
            bell <= 1'b0;
        end else begin
            bell <= !npu_ack && (bell || ring);
        end
    end

    assign rs1_f     = instr[19:15];
    assign rs2_f     = instr[24:20];
    assign exp_rd1   = (rs1_f == 5'd0) ? 32'd0 : shadow[rs1_f];
    assign exp_rd2   = (rs2_f == 5'd0) ? 32'd0 : shadow[rs2_f];
    assign exp_stall = mem_read_ex && (rd_ex != 5'd0) && ((rd_ex == rs1_f) || (rd_ex == rs2_f));

    // Control bit order: alu_src, mem_to_reg, reg_write, mem_read, mem_write, branch
    always_comb begin
        exp_imm  = 32'd0;
        exp_ex   = 6'b000000;
        exp_alu  = alu_add;
        known_op = 1'b1;
        case (instr[6:0])
            op_load: begin
                exp_imm = {{20{instr[31]}}, instr[31:20]};
                exp_ex  = 6'b111100;
            end
            op_store: begin
                exp_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                exp_ex  = 6'b100010;
            end
            op_branch: begin
                exp_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                exp_ex  = 6'b000001;
                exp_alu = alu_sub;
            end
            op_op: begin
                exp_ex = 6'b001000;
                case (instr[14:12])
                    3'b000:  exp_alu = instr[30] ? alu_sub : alu_add;
                    3'b010:  exp_alu = alu_slt;
                    3'b100:  exp_alu = alu_xor;
                    3'b110:  exp_alu = alu_or;
                    3'b111:  exp_alu = alu_and;
                    default: exp_alu = alu_add;
                endcase
            end
            op_npu: begin
                exp_ex  = 6'b001000;
                exp_alu = alu_npu;
            end
            op_op_imm: begin
                exp_imm  = {{20{instr[31]}}, instr[31:20]};
                known_op = 1'b0;
            end
            op_lui: begin
                exp_imm  = {instr[31:12], 12'd0};
                known_op = 1'b0;
            end
            op_jal: begin
                exp_imm  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                known_op = 1'b0;
            end
            default: begin
                known_op = 1'b0;
            end
        endcase
    end

    regs_match: assert property (@(posedge clk_50) disable iff (rst)
        (rd1 == exp_rd1) && (rd2 == exp_rd2)) else begin
        $error("Error rd1 = %h rd2 = %h, expected %h %h", rd1, rd2, exp_rd1, exp_rd2);
        fail_seen = 1'b1;
    end

    stall_bubble: assert property (@(posedge clk_50) disable iff (rst)
        (stall == exp_stall) && (!exp_stall || (ex_ctrl == 6'd0 && alu_ctrl == 4'd0))) else begin
        $error("Error stall = %h expected %h, ex_ctrl = %h alu_ctrl = %h",
               stall, exp_stall, ex_ctrl, alu_ctrl);
        fail_seen = 1'b1;
    end

    decode_match: assert property (@(posedge clk_50) disable iff (rst)
        known_op && !exp_stall && !(flush && !hit) |->
        (ex_ctrl == exp_ex) && (alu_ctrl == exp_alu)) else begin
        $error("Error ex_ctrl = %h alu_ctrl = %h, expected %h %h",
               ex_ctrl, alu_ctrl, exp_ex, exp_alu);
        fail_seen = 1'b1;
    end

    flush_squash: assert property (@(posedge clk_50) disable iff (rst)
        flush && !hit |-> ex_ctrl == 6'd0) else begin
        $error("Error ex_ctrl = %h during flush, expected 00", ex_ctrl);
        fail_seen = 1'b1;
    end

    imm_match: assert property (@(posedge clk_50) disable iff (rst) imm == exp_imm) else begin
        $error("Error imm = %h, expected %h for instr %h", imm, exp_imm, instr);
        fail_seen = 1'b1;
    end

    doorbell_match: assert property (@(posedge clk_50) disable iff (rst) en_npu == bell) else begin
        $error("Error en_npu = %h, expected %h", en_npu, bell);
        fail_seen = 1'b1;
    end

endmodule

bind id_stage id_stage_sva u_sva (.*);

`default_nettype wire

//--- dv/id_stage_tb.sv
// Decode-stage testbench with random and directed stimulus checked by bound assertions
`default_nettype none

module id_stage_tb
    import id_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles   = 10;
    localparam int preload_cycles = 150;
    localparam int mixed_cycles   = 800;
    localparam int bell_cycles    = 14;
    localparam int stim_cycles    = reset_cycles + preload_cycles + mixed_cycles + bell_cycles + 2;
    localparam int watchdog_ns    = stim_cycles * 8 + 400;

    logic        clk_50 = 1'b0;
    logic        rst;
    logic [31:0] instr;
    logic        mem_read_ex;
    logic [4:0]  rd_ex;
    logic [4:0]  wr;
    logic [31:0] wd;
    logic        reg_write;
    logic [4:0]  reg_addr;
    logic [31:0] reg_init;
    logic        reg_load;
    logic        flush;
    logic        hit;
    logic        npu_ack;
    logic        stall;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] imm;
    logic [5:0]  ex_ctrl;
    logic [3:0]  alu_ctrl;
    logic        en_npu;

    id_stage uut (.*);

    always #4 clk_50 = ~clk_50;

    function automatic logic [31:0] random_instr();
        logic [31:0] word;
        word = $urandom;
        case ($urandom % 9)
            0: word[6:0] = op_load;
            1: word[6:0] = op_store;
            2: word[6:0] = op_branch;
            3: word[6:0] = op_op;
            4: word[6:0] = op_op_imm;
            5: word[6:0] = op_lui;
            6: word[6:0] = op_jal;
            7: word[6:0] = op_npu;
            default: word[6:0] = 7'b1111111;
        endcase
        // Only base ISA funct7 for register ops
        if (word[6:0] == op_op) begin
            word[31:25] = 1'($urandom) ? 7'b0100000 : 7'b0000000;
        end
        return word;
    endfunction

    task automatic drive_random(input bit preload);
        logic [31:0] word;
        logic [4:0]  addr;
        word = random_instr();
        addr = 5'($urandom);
        @(posedge clk_50);
        instr       <= word;
        mem_read_ex <= 1'($urandom);
        case ($urandom % 4)
            0: rd_ex <= word[19:15];
            1: rd_ex <= word[24:20];
            default: rd_ex <= 5'($urandom);
        endcase
        reg_write <= 1'($urandom);
        // Collide with the preload address to exercise priority
        wr        <= (preload && 1'($urandom)) ? addr :
                     ((($urandom % 4) == 0) ? npu_doorbell_reg : 5'($urandom));
        wd        <= (($urandom % 4) == 0) ? 32'd0 : $urandom;
        reg_load  <= preload || (($urandom % 8) == 0);
        reg_addr  <= addr;
        reg_init  <= $urandom;
        flush     <= (($urandom % 4) == 0);
        hit       <= 1'($urandom);
        npu_ack   <= (($urandom % 8) == 0);
    endtask

    task automatic drive_bell(input bit we, input logic [31:0] data, input bit ack);
        @(posedge clk_50);
        reg_write <= we;
        wr        <= npu_doorbell_reg;
        wd        <= data;
        reg_load  <= 1'b0;
        npu_ack   <= ack;
    endtask

    initial begin
        void'($urandom(73));
        rst         <= 1'b1;
        instr       <= 32'd0;
        mem_read_ex <= 1'b0;
        rd_ex       <= 5'd0;
        wr          <= 5'd0;
        wd          <= 32'd0;
        reg_write   <= 1'b0;
        reg_addr    <= 5'd0;
        reg_init    <= 32'd0;
        reg_load    <= 1'b0;
        flush       <= 1'b0;
        hit         <= 1'b0;
        npu_ack     <= 1'b0;
        repeat (reset_cycles) @(posedge clk_50);
        rst <= 1'b0;
        repeat (preload_cycles) drive_random(1'b1);
        repeat (mixed_cycles) drive_random(1'b0);
        // Doorbell sequence of clear, zero write, ring and hold, ack, and ack against ring
        drive_bell(1'b0, 32'd0, 1'b1);
        drive_bell(1'b1, 32'd0, 1'b0);
        drive_bell(1'b0, 32'd0, 1'b0);
        drive_bell(1'b1, 32'h0000_00a5, 1'b0);
        repeat (3) drive_bell(1'b0, 32'd0, 1'b0);
        drive_bell(1'b0, 32'd0, 1'b1);
        drive_bell(1'b0, 32'd0, 1'b0);
        drive_bell(1'b1, 32'h8000_0001, 1'b1);
        repeat (4) drive_bell(1'b0, 32'd0, 1'b0);
        repeat (2) @(posedge clk_50);
        // Let the assertions of the last edge settle
        @(negedge clk_50);
        if (uut.u_sva.fail_seen) begin
            $display("Test failures found");
            $fatal(1, "Assertion failures were reported during the run");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

    initial begin
        wait (uut.u_sva.fail_seen);
        $display("Test failures found");
        $fatal(1, "A bound assertion failed");
    end

    initial begin
        #(watchdog_ns);
        $display("Test failures found");
        $fatal(1, "Watchdog expired before the stimulus finished");
    end

endmodule

`default_nettype wire

//--- project.f
hdl/id_pkg.sv
hdl/id_ctrl_if.sv
hdl/hazard_detect.sv
hdl/decode_control.sv
hdl/reg_file.sv
hdl/imm_gen.sv
hdl/issue_gate.sv
hdl/id_stage.sv
dv/id_stage_sva.sv
dv/id_stage_tb.sv

//--- Makefile
TOP = id_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f project.f

sim:
	verilator --binary --assert --timing --timescale 1ns/1ps --top-module $(TOP) \
		--Mdir build -f project.f
	./build/V$(TOP) +verilator+error+limit+1000

clean:
	rm -rf build
